//--- logic/hub75_consts.svh
`ifndef HUB75_CONSTS_SVH
`define HUB75_CONSTS_SVH

////////////////////////////////////////
// panel geometry
////////////////////////////////////////

// columns on one panel, one shift per column
`define PANEL_WIDTH 64

// physical rows, top and bottom half together
`define PANEL_ROWS 32

// 1/16 scan, each address lights one row per half
`define SCAN_ROWS 16

// bits per color channel, one bit plane each
`define COLOR_PLANES 2

////////////////////////////////////////
// FM6126 start-up and display timing
////////////////////////////////////////

// trailing columns with latch high, first config register
`define INIT_LATCH1 12

// trailing columns with latch high, second config register
`define INIT_LATCH2 13

// lit cycles of plane 0, plane p gets this shifted left by p
`define DISPLAY_BASE 32

`endif

//--- logic/hub75Pkg.sv
`default_nettype none
`include "hub75_consts.svh"

package hub75Pkg;

    // column index along one panel row
    typedef logic [$clog2(`PANEL_WIDTH)-1:0] colAddr;

    // scan row address, A..D lines
    typedef logic [$clog2(`SCAN_ROWS)-1:0] rowAddr;

    // host pixel position, {row[4:0], col[5:0]}
    typedef logic [$clog2(`PANEL_ROWS)+$clog2(`PANEL_WIDTH)-1:0] pixAddr;

    // red[1:0], green[1:0], blue[1:0]
    typedef logic [3*`COLOR_PLANES-1:0] pixColor;

    // one bit per channel, red in bit 2
    typedef logic [2:0] rgbBits;

    // everything that goes out on the HUB75 connector
    typedef struct packed {
        rgbBits rgb1;
        rgbBits rgb2;
        logic   latch;
        logic   pixClk;
        logic   blank;
        rowAddr row;
    } hub75Pins;

    // LEDs off, no clock, no latch
    localparam hub75Pins PINS_IDLE = '{rgb1: '0, rgb2: '0, latch: 1'b0,
                                       pixClk: 1'b0, blank: 1'b1, row: '0};

    typedef enum logic [2:0] {INIT_IDLE, SHIFT_LOW, SHIFT_HIGH, NEXT_REG, INIT_DONE} initState;

    typedef enum logic [2:0] {
        SCAN_SHIFT_LOW,
        SCAN_SHIFT_HIGH,
        SCAN_LATCH,
        SCAN_SHOW,
        SCAN_NEXT
    } scanState;

endpackage

`default_nettype wire

//--- logic/panelInit.sv
`timescale 1ns/1ps
`default_nettype none
`include "hub75_consts.svh"

module panelInit (
    input  logic               clk_in,
    input  logic               reset,
    output hub75Pkg::hub75Pins initPins,
    output logic               initDone
);

    // per-register data, indexed by column mod 16
    // reg one is all ones except column 0
    localparam logic [15:0] REG1_PATTERN = 16'hFFFE;
    // reg two has a single one at column 9
    localparam logic [15:0] REG2_PATTERN = 16'h0200;

    localparam hub75Pkg::colAddr LAST_COL = hub75Pkg::colAddr'(`PANEL_WIDTH - 1);
    localparam hub75Pkg::colAddr LATCH1_START =
        hub75Pkg::colAddr'(`PANEL_WIDTH - `INIT_LATCH1);
    localparam hub75Pkg::colAddr LATCH2_START =
        hub75Pkg::colAddr'(`PANEL_WIDTH - `INIT_LATCH2);

    hub75Pkg::initState state;
    hub75Pkg::colAddr   col;
    // 0 while sending reg one, 1 for reg two
    logic               regSel;
    // counts the two idle cycles between bursts
    logic               idleCnt;
    logic               dataBit;
    logic               latchOn;
    hub75Pkg::hub75Pins pinsNext;

    assign dataBit = regSel ? REG2_PATTERN[col[3:0]] : REG1_PATTERN[col[3:0]];
    // latch covers the tail of each burst
    assign latchOn = regSel ? (col >= LATCH2_START) : (col >= LATCH1_START);

    ////////////////////////////////////////
    // pin values for the current state
    ////////////////////////////////////////
    always_comb begin
        pinsNext = hub75Pkg::PINS_IDLE;
        if (state == hub75Pkg::SHIFT_LOW || state == hub75Pkg::SHIFT_HIGH) begin
            // same bit on every channel of both halves
            pinsNext.rgb1   = {3{dataBit}};
            pinsNext.rgb2   = {3{dataBit}};
            pinsNext.latch  = latchOn;
            pinsNext.pixClk = (state == hub75Pkg::SHIFT_HIGH);
        end
    end

    ////////////////////////////////////////
    // burst sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk_in, posedge reset) begin
        if (reset) begin
            state    <= hub75Pkg::INIT_IDLE;
            col      <= '0;
            regSel   <= 1'b0;
            idleCnt  <= 1'b0;
            initDone <= 1'b0;
        end else begin
            case (state)
                hub75Pkg::INIT_IDLE: begin
                    col   <= '0;
                    state <= hub75Pkg::SHIFT_LOW;
                end
                // data set up, clock low
                hub75Pkg::SHIFT_LOW: begin
                    state <= hub75Pkg::SHIFT_HIGH;
                end
                // clock high, then next column or end of burst
                hub75Pkg::SHIFT_HIGH: begin
                    if (col == LAST_COL) begin
                        col     <= '0;
                        idleCnt <= 1'b0;
                        state   <= hub75Pkg::NEXT_REG;
                    end else begin
                        col   <= hub75Pkg::colAddr'(col + 1'b1);
                        state <= hub75Pkg::SHIFT_LOW;
                    end
                end
                // two idle cycles after each burst
                hub75Pkg::NEXT_REG: begin
                    idleCnt <= 1'b1;
                    if (idleCnt) begin
                        if (regSel) begin
                            initDone <= 1'b1;
                            state    <= hub75Pkg::INIT_DONE;
                        end else begin
                            regSel <= 1'b1;
                            state  <= hub75Pkg::SHIFT_LOW;
                        end
                    end
                end
                // parked, scanner owns the pins from here
                hub75Pkg::INIT_DONE: begin
                    state <= hub75Pkg::INIT_DONE;
                end
                default: begin
                    state <= hub75Pkg::INIT_IDLE;
                end
            endcase
        end
    end

    // registered pins, one cycle behind the state
    always_ff @(posedge clk_in, posedge reset) begin
        if (reset) begin
            initPins <= hub75Pkg::PINS_IDLE;
        end else begin
            initPins <= pinsNext;
        end
    end

endmodule

`default_nettype wire

//--- logic/frameBuffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "hub75_consts.svh"

module frameBuffer (
    input  logic              clk_in,
    input  logic              wrEn,
    input  hub75Pkg::pixAddr  wrAddr,
    input  hub75Pkg::pixColor wrColor,
    input  hub75Pkg::rowAddr  rdRow,
    input  hub75Pkg::colAddr  rdCol,
    output hub75Pkg::pixColor topColor,
    output hub75Pkg::pixColor botColor
);

    localparam int COL_BITS = $bits(hub75Pkg::colAddr);
    localparam int ROW_BITS = $bits(hub75Pkg::rowAddr);
    localparam int IDX_BITS = COL_BITS + ROW_BITS;
    // one half of the panel, scan rows times columns
    localparam int DEPTH    = `SCAN_ROWS * `PANEL_WIDTH;

    logic [IDX_BITS-1:0] wrIdx;
    logic [IDX_BITS-1:0] rdIdx;
    // row bit 4 picks top or bottom half
    logic                wrHalf;
    hub75Pkg::pixColor   rdData [2];

    assign wrIdx  = wrAddr[IDX_BITS-1:0];
    assign wrHalf = wrAddr[IDX_BITS];
    // same position in both halves, read together
    assign rdIdx  = {rdRow, rdCol};

    ////////////////////////////////////////
    // one memory per half
    ////////////////////////////////////////
    for (genvar h = 0; h < 2; h++) begin : gHalf
        hub75Pkg::pixColor mem [DEPTH];

        always_ff @(posedge clk_in) begin
            if (wrEn && (wrHalf == 1'(h))) begin
                mem[wrIdx] <= wrColor;
            end
            // registered read, data one cycle after the address
            rdData[h] <= mem[rdIdx];
        end
    end

    // h = 0 is rows 0..15, h = 1 is rows 16..31
    assign topColor = rdData[0];
    assign botColor = rdData[1];

endmodule

`default_nettype wire

//--- logic/scanDriver.sv
`timescale 1ns/1ps
`default_nettype none
`include "hub75_consts.svh"

module scanDriver (
    input  logic               clk_in,
    input  logic               reset,
    input  hub75Pkg::hub75Pins initPins,
    input  logic               initDone,
    output hub75Pkg::rowAddr   rdRow,
    output hub75Pkg::colAddr   rdCol,
    input  hub75Pkg::pixColor  topColor,
    input  hub75Pkg::pixColor  botColor,
    output hub75Pkg::hub75Pins panel
);

    localparam int PLANE_BITS = $clog2(`COLOR_PLANES);
    // longest lit period, last plane
    localparam int DISP_MAX   = `DISPLAY_BASE << (`COLOR_PLANES - 1);
    localparam int DISP_BITS  = $clog2(DISP_MAX + 1);

    typedef logic [PLANE_BITS-1:0] planeIdx;
    typedef logic [DISP_BITS-1:0]  dispCount;

    localparam hub75Pkg::colAddr LAST_COL   = hub75Pkg::colAddr'(`PANEL_WIDTH - 1);
    localparam planeIdx          LAST_PLANE = planeIdx'(`COLOR_PLANES - 1);

    hub75Pkg::scanState state;
    hub75Pkg::colAddr   col;
    // row being shifted and read
    hub75Pkg::rowAddr   scanRow;
    // row currently on the address lines
    hub75Pkg::rowAddr   shownRow;
    planeIdx            plane;
    dispCount           dispCnt;
    dispCount           dispLast;
    hub75Pkg::hub75Pins ctrlNext;
    hub75Pkg::hub75Pins ctrlQ;
    logic               shiftNext;
    logic               shiftQ;
    hub75Pkg::hub75Pins scanPins;

    // bit p of each channel of one pixel
    function automatic hub75Pkg::rgbBits planeBits(hub75Pkg::pixColor color, planeIdx p);
        planeBits = {color[2*`COLOR_PLANES + p], color[`COLOR_PLANES + p], color[p]};
    endfunction

    assign rdRow    = scanRow;
    assign rdCol    = col;
    // lit time doubles with each plane
    assign dispLast = dispCount'((`DISPLAY_BASE << plane) - 1);

    ////////////////////////////////////////
    // row / plane / column sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk_in, posedge reset) begin
        if (reset) begin
            state    <= hub75Pkg::SCAN_SHIFT_LOW;
            col      <= '0;
            scanRow  <= '0;
            shownRow <= '0;
            plane    <= '0;
            dispCnt  <= '0;
        end else if (initDone) begin
            case (state)
                // read issued for col
                hub75Pkg::SCAN_SHIFT_LOW: begin
                    state <= hub75Pkg::SCAN_SHIFT_HIGH;
                end
                // read data for col is valid here
                hub75Pkg::SCAN_SHIFT_HIGH: begin
                    if (col == LAST_COL) begin
                        col   <= '0;
                        state <= hub75Pkg::SCAN_LATCH;
                    end else begin
                        col   <= hub75Pkg::colAddr'(col + 1'b1);
                        state <= hub75Pkg::SCAN_SHIFT_LOW;
                    end
                end
                // row lines move with the latch
                hub75Pkg::SCAN_LATCH: begin
                    shownRow <= scanRow;
                    dispCnt  <= '0;
                    state    <= hub75Pkg::SCAN_SHOW;
                end
                hub75Pkg::SCAN_SHOW: begin
                    if (dispCnt == dispLast) begin
                        state <= hub75Pkg::SCAN_NEXT;
                    end else begin
                        dispCnt <= dispCount'(dispCnt + 1'b1);
                    end
                end
                // all planes of a row, then next row, 15 wraps to 0
                hub75Pkg::SCAN_NEXT: begin
                    if (plane == LAST_PLANE) begin
                        plane   <= '0;
                        scanRow <= hub75Pkg::rowAddr'(scanRow + 1'b1);
                    end else begin
                        plane <= planeIdx'(plane + 1'b1);
                    end
                    state <= hub75Pkg::SCAN_SHIFT_LOW;
                end
                default: begin
                    state <= hub75Pkg::SCAN_SHIFT_LOW;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // control pins per state
    ////////////////////////////////////////
    always_comb begin
        ctrlNext     = hub75Pkg::PINS_IDLE;
        ctrlNext.row = shownRow;
        shiftNext    = 1'b0;
        case (state)
            hub75Pkg::SCAN_SHIFT_LOW: begin
                shiftNext = 1'b1;
            end
            hub75Pkg::SCAN_SHIFT_HIGH: begin
                shiftNext       = 1'b1;
                ctrlNext.pixClk = 1'b1;
            end
            hub75Pkg::SCAN_LATCH: begin
                ctrlNext.latch = 1'b1;
                ctrlNext.row   = scanRow;
            end
            hub75Pkg::SCAN_SHOW: begin
                ctrlNext.blank = 1'b0;
            end
            default: begin
            end
        endcase
    end

    // ctrlQ lines up with the memory output, so data and clock match
    always_comb begin
        scanPins = ctrlQ;
        if (shiftQ) begin
            scanPins.rgb1 = planeBits(topColor, plane);
            scanPins.rgb2 = planeBits(botColor, plane);
        end
    end

    always_ff @(posedge clk_in, posedge reset) begin
        if (reset) begin
            ctrlQ  <= hub75Pkg::PINS_IDLE;
            shiftQ <= 1'b0;
            panel  <= hub75Pkg::PINS_IDLE;
        end else begin
            ctrlQ  <= ctrlNext;
            shiftQ <= shiftNext;
            // init sequencer owns the connector until it is done
            panel  <= initDone ? scanPins : initPins;
        end
    end

endmodule

`default_nettype wire

//--- logic/hub75Top.sv
`timescale 1ns/1ps
`default_nettype none

module hub75Top (
    input  logic               clk_in,
    input  logic               reset,
    input  logic               wrEn,
    input  hub75Pkg::pixAddr   wrAddr,
    input  hub75Pkg::pixColor  wrColor,
    output hub75Pkg::hub75Pins panel
);

    // init sequencer to scanner
    hub75Pkg::hub75Pins initPins;
    logic               initDone;

    // scanner read port
    hub75Pkg::rowAddr   rdRow;
    hub75Pkg::colAddr   rdCol;
    hub75Pkg::pixColor  topColor;
    hub75Pkg::pixColor  botColor;

    ////////////////////////////////////////
    // FM6126 start-up bursts
    ////////////////////////////////////////
    panelInit i_panelInit (
        .clk_in   (clk_in),
        .reset    (reset),
        .initPins (initPins),
        .initDone (initDone)
    );

    // pixel store, host writes and scanner reads
    frameBuffer i_frameBuffer (
        .clk_in   (clk_in),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrColor  (wrColor),
        .rdRow    (rdRow),
        .rdCol    (rdCol),
        .topColor (topColor),
        .botColor (botColor)
    );

    ////////////////////////////////////////
    // scan driver, owns the panel pins
    ////////////////////////////////////////
    scanDriver i_scanDriver (
        .clk_in   (clk_in),
        .reset    (reset),
        .initPins (initPins),
        .initDone (initDone),
        .rdRow    (rdRow),
        .rdCol    (rdCol),
        .topColor (topColor),
        .botColor (botColor),
        .panel    (panel)
    );

endmodule

`default_nettype wire

//--- sim/hub75_assert.sv
`timescale 1ns/1ps
`default_nettype none

module hub75Assert (
    input logic               clk_in,
    input logic               reset,
    input hub75Pkg::hub75Pins panel
);

    // failures seen so far, the testbench polls this
    int errCount = 0;

    ////////////////////////////////////////
    // panel connector rules
    ////////////////////////////////////////

    // latch only while the LEDs are off
    latchBlanked: assert property (@(posedge clk_in) disable iff (reset)
        panel.latch |-> panel.blank)
        else begin
            errCount++;
            $error("latch high while blank is low");
        end

    // latch moves only with the pixel clock low
    latchSteady: assert property (@(posedge clk_in) disable iff (reset)
        panel.pixClk |-> $stable(panel.latch))
        else begin
            errCount++;
            $error("latch changed while pixClk is high");
        end

    // no shifting while a row is lit
    noShiftLit: assert property (@(posedge clk_in) disable iff (reset)
        !panel.blank |-> !panel.pixClk)
        else begin
            errCount++;
            $error("pixClk toggled during the lit period");
        end

    // row lines hold for the whole lit period
    rowHeld: assert property (@(posedge clk_in) disable iff (reset)
        (!panel.blank && $past(!panel.blank)) |-> $stable(panel.row))
        else begin
            errCount++;
            $error("row address changed while lit");
        end

endmodule

bind hub75Top hub75Assert i_assert (
    .clk_in (clk_in),
    .reset  (reset),
    .panel  (panel)
);

`default_nettype wire

//--- sim/hub75Tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "hub75_consts.svh"

module hub75Tb;

    // vector file layout, one block per checked scan row
    localparam int BLK_LEN  = 1 + 4 * `PANEL_WIDTH;
    localparam int REW_BASE = 2 * BLK_LEN;
    localparam int VEC_LEN  = REW_BASE + 5;

    logic               clk_in;
    logic               reset;
    logic               wrEn;
    hub75Pkg::pixAddr   wrAddr;
    hub75Pkg::pixColor  wrColor;
    hub75Pkg::hub75Pins panel;

    logic [7:0] vecMem [VEC_LEN];
    // expected {rgb1, rgb2} per block, plane and column
    logic [5:0] expWord [2][2][`PANEL_WIDTH];
    logic [3:0] checkRow [2];

    // panel model state
    logic [5:0]         shiftReg [`PANEL_WIDTH];
    hub75Pkg::hub75Pins prevPins = hub75Pkg::PINS_IDLE;
    int shiftCnt     = 0;
    int latchEdges   = 0;
    int latchFalls   = 0;
    int litCnt       = 0;
    int litPlane     = 0;
    int litChecks    = 0;
    int checkedSnaps = 0;

    hub75Top i_dut (
        .clk_in  (clk_in),
        .reset   (reset),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrColor (wrColor),
        .panel   (panel)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    ////////////////////////////////////////
    // error exits
    ////////////////////////////////////////
    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic valueMismatch(string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        abortRun();
    endtask

    task automatic plainError(string msg);
        $display("ERROR: %s", msg);
        abortRun();
    endtask

    // one host write per clock, strobe left high
    task automatic writePixel(hub75Pkg::pixAddr addr, hub75Pkg::pixColor color);
        @(posedge clk_in);
        wrEn    <= 1'b1;
        wrAddr  <= addr;
        wrColor <= color;
    endtask

    task automatic loadExpected();
        int base;
        for (int b = 0; b < 2; b++) begin
            base = b * BLK_LEN;
            checkRow[b] = vecMem[base][3:0];
            for (int c = 0; c < `PANEL_WIDTH; c++) begin
                expWord[b][0][c] = vecMem[base + 1 + 2 * `PANEL_WIDTH + c][5:0];
                expWord[b][1][c] = vecMem[base + 1 + 3 * `PANEL_WIDTH + c][5:0];
            end
        end
    endtask

    // compare what the panel holds when latch drops
    task automatic checkSnapshot();
        int n;
        int edges;
        logic [5:0] want;
        n = latchFalls - 2;
        assert (shiftCnt == `PANEL_WIDTH)
            else valueMismatch($sformatf("%0d columns before latch %0d", shiftCnt, latchFalls));
        if (latchFalls < 2) begin
            // FM6126 config registers, same bit on all six lines
            edges = (latchFalls == 0) ? `INIT_LATCH1 : `INIT_LATCH2;
            assert (latchEdges == edges)
                else valueMismatch($sformatf("init latch held %0d edges", latchEdges));
            for (int c = 0; c < `PANEL_WIDTH; c++) begin
                if (latchFalls == 0) begin
                    want = (c % 16 != 0) ? 6'h3F : 6'h00;
                end else begin
                    want = (c % 16 == 9) ? 6'h3F : 6'h00;
                end
                assert (shiftReg[`PANEL_WIDTH - 1 - c] == want)
                    else valueMismatch($sformatf("init reg %0d col %0d", latchFalls + 1, c));
            end
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (checkRow[b] == (n / 2) % `SCAN_ROWS) begin
                    for (int c = 0; c < `PANEL_WIDTH; c++) begin
                        assert (shiftReg[`PANEL_WIDTH - 1 - c] == expWord[b][n % 2][c])
                            else valueMismatch($sformatf("row %0d plane %0d col %0d: %h",
                                checkRow[b], n % 2, c, shiftReg[`PANEL_WIDTH - 1 - c]));
                    end
                    checkedSnaps++;
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // panel model, sampled mid-cycle
    ////////////////////////////////////////
    always @(negedge clk_in) begin
        if (!reset) begin
            assert (i_dut.i_assert.errCount == 0)
                else plainError("a protocol assertion on the panel pins fired");
            // LEDs stay dark through both bursts
            if (latchFalls < 2) begin
                assert (panel.blank) else valueMismatch("blank low during the init bursts");
            end
            // shift on the pixClk rising edge, newest word at index 0
            if (panel.pixClk && !prevPins.pixClk) begin
                for (int i = `PANEL_WIDTH - 1; i > 0; i--) begin
                    shiftReg[i] = shiftReg[i - 1];
                end
                shiftReg[0] = {panel.rgb1, panel.rgb2};
                shiftCnt++;
                if (panel.latch) begin
                    latchEdges++;
                end
            end
            // row lines move with the scan latch
            if (panel.latch && !prevPins.latch && latchFalls >= 2) begin
                assert (panel.row == ((latchFalls - 2) / 2) % `SCAN_ROWS)
                    else valueMismatch($sformatf("row %0d at scan latch %0d",
                        panel.row, latchFalls - 2));
            end
            if (!panel.latch && prevPins.latch) begin
                checkSnapshot();
                litPlane   = (latchFalls - 2) % 2;
                latchFalls++;
                latchEdges = 0;
                shiftCnt   = 0;
            end
            // lit period length per plane
            if (!panel.blank) begin
                litCnt++;
            end else if (!prevPins.blank) begin
                assert (litCnt == (`DISPLAY_BASE << litPlane))
                    else valueMismatch($sformatf("lit %0d cycles on plane %0d", litCnt, litPlane));
                litChecks++;
                litCnt = 0;
            end
            prevPins = panel;
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int timer;
        int base;
        hub75Pkg::pixAddr rewAddr;
        reset   <= 1'b1;
        wrEn    <= 1'b0;
        wrAddr  <= '0;
        wrColor <= '0;
        $readmemh("sim/hub75_vectors.txt", vecMem);
        assert (!$isunknown(vecMem[VEC_LEN - 1]))
            else plainError("vector file sim/hub75_vectors.txt is missing or short");
        loadExpected();

        // idle pins while reset is held
        repeat (8) @(posedge clk_in);
        @(negedge clk_in);
        assert (panel.blank && !panel.latch && !panel.pixClk && panel.rgb1 == '0
                && panel.rgb2 == '0 && panel.row == '0)
            else valueMismatch($sformatf("pins %h during reset", panel));
        repeat (8) @(posedge clk_in);
        reset <= 1'b0;

        // both halves of each checked row, written during init
        for (int b = 0; b < 2; b++) begin
            base = b * BLK_LEN;
            for (int c = 0; c < `PANEL_WIDTH; c++) begin
                writePixel({1'b0, checkRow[b], 6'(c)}, vecMem[base + 1 + c][5:0]);
                writePixel({1'b1, checkRow[b], 6'(c)}, vecMem[base + 1 + `PANEL_WIDTH + c][5:0]);
            end
        end
        @(posedge clk_in);
        wrEn <= 1'b0;

        timer = 0;
        while (latchFalls < 2) begin
            @(posedge clk_in);
            timer++;
            if (timer > 2000) begin
                plainError("timeout waiting for the init bursts to latch");
            end
        end

        // rewrite once that row has shown both planes
        rewAddr = {vecMem[REW_BASE][4:0], vecMem[REW_BASE + 1][5:0]};
        timer = 0;
        while (latchFalls < 2 + 2 * (rewAddr[9:6] + 1)) begin
            @(posedge clk_in);
            timer++;
            if (timer > 8000) begin
                plainError("timeout waiting for the first scan of the rewritten row");
            end
        end
        writePixel(rewAddr, vecMem[REW_BASE + 2][5:0]);
        @(posedge clk_in);
        wrEn <= 1'b0;
        for (int b = 0; b < 2; b++) begin
            if (checkRow[b] == rewAddr[9:6]) begin
                expWord[b][0][rewAddr[5:0]] = vecMem[REW_BASE + 3][5:0];
                expWord[b][1][rewAddr[5:0]] = vecMem[REW_BASE + 4][5:0];
            end
        end

        // two full frames of scan latches
        timer = 0;
        while (latchFalls < 2 + 4 * `SCAN_ROWS) begin
            @(posedge clk_in);
            timer++;
            if (timer > 20000) begin
                plainError("timeout waiting for two scan frames");
            end
        end

        if (checkedSnaps == 8 && litChecks >= 4 * `SCAN_ROWS - 1) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            plainError($sformatf("only %0d snapshots and %0d lit periods were checked",
                checkedSnaps, litChecks));
        end
    end

endmodule

`default_nettype wire

//--- sim/hub75_vectors.txt
// per checked scan row: row, 64 top colors, 64 bottom colors, plane 0 words, plane 1 words
// 32 values per line, words are {rgb1, rgb2}; last line: panel row, col, new color, words
03
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F 30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F
3F 3E 3D 3C 3B 3A 39 38 37 36 35 34 33 32 31 30 2F 2E 2D 2C 2B 2A 29 28 27 26 25 24 23 22 21 20
1F 1E 1D 1C 1B 1A 19 18 17 16 15 14 13 12 11 10 0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00
07 0E 07 0E 15 1C 15 1C 07 0E 07 0E 15 1C 15 1C 23 2A 23 2A 31 38 31 38 23 2A 23 2A 31 38 31 38
07 0E 07 0E 15 1C 15 1C 07 0E 07 0E 15 1C 15 1C 23 2A 23 2A 31 38 31 38 23 2A 23 2A 31 38 31 38
07 07 0E 0E 07 07 0E 0E 15 15 1C 1C 15 15 1C 1C 07 07 0E 0E 07 07 0E 0E 15 15 1C 1C 15 15 1C 1C
23 23 2A 2A 23 23 2A 2A 31 31 38 38 31 31 38 38 23 23 2A 2A 23 23 2A 2A 31 31 38 38 31 31 38 38
0C
15 14 17 16 11 10 13 12 1D 1C 1F 1E 19 18 1B 1A 05 04 07 06 01 00 03 02 0D 0C 0F 0E 09 08 0B 0A
35 34 37 36 31 30 33 32 3D 3C 3F 3E 39 38 3B 3A 25 24 27 26 21 20 23 22 2D 2C 2F 2E 29 28 2B 2A
2A 2B 28 29 2E 2F 2C 2D 22 23 20 21 26 27 24 25 3A 3B 38 39 3E 3F 3C 3D 32 33 30 31 36 37 34 35
0A 0B 08 09 0E 0F 0C 0D 02 03 00 01 06 07 04 05 1A 1B 18 19 1E 1F 1C 1D 12 13 10 11 16 17 14 15
38 31 38 31 2A 23 2A 23 38 31 38 31 2A 23 2A 23 1C 15 1C 15 0E 07 0E 07 1C 15 1C 15 0E 07 0E 07
38 31 38 31 2A 23 2A 23 38 31 38 31 2A 23 2A 23 1C 15 1C 15 0E 07 0E 07 1C 15 1C 15 0E 07 0E 07
07 07 0E 0E 07 07 0E 0E 15 15 1C 1C 15 15 1C 1C 07 07 0E 0E 07 07 0E 0E 15 15 1C 1C 15 15 1C 1C
23 23 2A 2A 23 23 2A 2A 31 31 38 38 31 31 38 38 23 23 2A 2A 23 23 2A 2A 31 31 38 38 31 31 38 38
03 05 2A 04 3F

//--- project.f
+incdir+logic
logic/hub75Pkg.sv
logic/panelInit.sv
logic/frameBuffer.sv
logic/scanDriver.sv
logic/hub75Top.sv
sim/hub75_assert.sv
sim/hub75Tb.sv

//--- Bender.yml
package:
  name: hub75

sources:
  - include_dirs:
      - logic
    files:
      - logic/hub75Pkg.sv
      - logic/panelInit.sv
      - logic/frameBuffer.sv
      - logic/scanDriver.sv
      - logic/hub75Top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/hub75_assert.sv
      - sim/hub75Tb.sv
